// File: rtl/fpdiv_pkg.sv
package fpdiv_pkg;

  // binary32 field widths
  localparam int MANT_W   = 24;            // hidden bit included
  localparam int FRAC_W   = MANT_W - 1;
  localparam int EXP_W    = 8;
  localparam int EXP_BIAS = 127;
  localparam int EXP_DW   = 10;            // signed working exponent
  localparam logic [EXP_W-1:0] EXP_MAX = '1;

  // radix-4 recurrence sizing
  localparam int REM_W      = 28;          // sign, one integer bit, 26 fraction bits
  localparam int ITER_COUNT = 14;          // two quotient bits per step
  localparam int QUO_W      = 2 * ITER_COUNT;
  localparam int CNT_W      = $clog2(ITER_COUNT);

  localparam logic [31:0] QNAN = 32'h7fc0_0000;

  typedef struct packed {
    logic              sign;
    logic [EXP_W-1:0]  exp;
    logic [FRAC_W-1:0] frac;
  } fp32_fields_t;

  // same word, moved as a bus or split into fields
  typedef union packed {
    logic [31:0]  raw;
    fp32_fields_t f;
  } fp32_u;

  // unpacked operand pair, held for the whole division
  typedef struct packed {
    logic                     sign;
    logic signed [EXP_DW-1:0] exp_diff;     // biased, before quotient normalization
    logic [MANT_W-1:0]        mant_a;       // dividend, leading one at top
    logic [MANT_W-1:0]        mant_b;       // divisor, leading one at top
    logic                     special;
    logic [31:0]              special_word;
  } div_op_t;

  // quotient as it leaves the recurrence
  typedef struct packed {
    logic [QUO_W-1:0] quo;      // one's place of a/b at bit QUO_W-2
    logic             sticky;   // nonzero final remainder
  } quo_raw_t;

endpackage

// File: rtl/fp_unpack.sv
`timescale 1ns/1ps

module fp_unpack (
  input  fpdiv_pkg::fp32_u   a,
  input  fpdiv_pkg::fp32_u   b,
  output fpdiv_pkg::div_op_t op
);
  import fpdiv_pkg::*;

  logic                     a_zero, a_inf, a_nan;
  logic                     b_zero, b_inf, b_nan;
  logic                     sign;
  logic [MANT_W-1:0]        ma, mb;
  logic [4:0]               lza, lzb;
  logic signed [EXP_DW-1:0] ea, eb;

  // leading zero count, full width for a zero word
  function automatic logic [4:0] lead_zeros(input logic [MANT_W-1:0] m);
    logic [4:0] n;
    logic       seen;
    n    = '0;
    seen = 1'b0;
    for (int i = MANT_W - 1; i >= 0; i--) begin
      seen = seen | m[i];
      if (!seen)
        n = n + 5'd1;
    end
    return n;
  endfunction

  assign a_zero = (a.f.exp == '0) && (a.f.frac == '0);
  assign a_inf  = (a.f.exp == EXP_MAX) && (a.f.frac == '0);
  assign a_nan  = (a.f.exp == EXP_MAX) && (a.f.frac != '0);
  assign b_zero = (b.f.exp == '0) && (b.f.frac == '0);
  assign b_inf  = (b.f.exp == EXP_MAX) && (b.f.frac == '0);
  assign b_nan  = (b.f.exp == EXP_MAX) && (b.f.frac != '0);

  assign sign = a.f.sign ^ b.f.sign;

  // hidden bit only for normals, subnormals get shifted up below
  assign ma  = {a.f.exp != '0, a.f.frac};
  assign mb  = {b.f.exp != '0, b.f.frac};
  assign lza = lead_zeros(ma);
  assign lzb = lead_zeros(mb);

  // subnormals sit at exponent 1, each shift step costs one
  assign ea = $signed({2'b00, (a.f.exp == '0) ? 8'd1 : a.f.exp}) - $signed({5'd0, lza});
  assign eb = $signed({2'b00, (b.f.exp == '0) ? 8'd1 : b.f.exp}) - $signed({5'd0, lzb});

  always_comb begin
    op.sign         = sign;
    op.exp_diff     = ea - eb + EXP_DW'(EXP_BIAS);
    op.mant_a       = ma << lza;
    op.mant_b       = mb << lzb;
    op.special      = 1'b1;
    op.special_word = QNAN;
    if (a_nan || b_nan || (a_inf && b_inf) || (a_zero && b_zero))
      op.special_word = QNAN;
    else if (a_inf || b_zero)
      op.special_word = {sign, EXP_MAX, FRAC_W'(0)};  // signed infinity
    else if (a_zero || b_inf)
      op.special_word = {sign, 31'd0};
    else
      op.special = 1'b0;
  end

endmodule

// File: rtl/srt4_qds.sv
`timescale 1ns/1ps

module srt4_qds (
  input  logic [6:0]        rem_est,   // 4w, two's complement, 4 fraction bits
  input  logic [2:0]        div_est,   // divisor bits after the leading one
  output logic signed [2:0] digit
);

  logic [27:0]       row;   // {m2, m1, m0, m-1}
  logic signed [6:0] y;
  logic signed [6:0] m2, m1, m0, mn1;

  assign y = $signed(rem_est);

  // thresholds in units of 1/16, divisor taken in [1/2, 1)
  always_comb begin
    case (div_est)
      3'd0:    row = {7'sd12, 7'sd4, -7'sd4, -7'sd13};
      3'd1:    row = {7'sd14, 7'sd4, -7'sd6, -7'sd15};
      3'd2:    row = {7'sd15, 7'sd4, -7'sd6, -7'sd16};
      3'd3:    row = {7'sd16, 7'sd4, -7'sd6, -7'sd18};
      3'd4:    row = {7'sd18, 7'sd6, -7'sd8, -7'sd20};
      3'd5:    row = {7'sd20, 7'sd6, -7'sd8, -7'sd20};
      3'd6:    row = {7'sd20, 7'sd8, -7'sd8, -7'sd22};
      default: row = {7'sd24, 7'sd8, -7'sd8, -7'sd24};
    endcase
  end

  assign m2  = row[27:21];
  assign m1  = row[20:14];
  assign m0  = row[13:7];
  assign mn1 = row[6:0];

  // truncated estimate is exact against multiples of 1/16
  always_comb begin
    if (y >= m2)
      digit = 3'sd2;
    else if (y >= m1)
      digit = 3'sd1;
    else if (y >= m0)
      digit = 3'sd0;
    else if (y >= mn1)
      digit = -3'sd1;
    else
      digit = -3'sd2;
  end

endmodule

// File: rtl/srt4_iter.sv
`timescale 1ns/1ps

module srt4_iter (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         start,
  input  logic [fpdiv_pkg::MANT_W-1:0] dividend,
  input  logic [fpdiv_pkg::MANT_W-1:0] divisor,
  output logic                         done,
  output fpdiv_pkg::quo_raw_t          res
);
  import fpdiv_pkg::*;

  logic [REM_W-1:0]  w;          // partial remainder, bit 26 is the one's place
  logic [REM_W-1:0]  w_shift;
  logic [REM_W-1:0]  d1, d2;
  logic [REM_W-1:0]  qd;
  logic [REM_W-1:0]  w_next;
  logic [QUO_W-1:0]  q_acc, qm_acc;   // Q and Q minus one ulp
  logic [QUO_W-1:0]  q_src, qm_src;
  logic signed [2:0] digit;
  logic signed [2:0] digit_m1;
  logic [CNT_W-1:0]  cnt;
  logic              running;

  assign d1      = {2'b00, divisor, 2'b00};   // d/2 in [1/2, 1)
  assign d2      = {1'b0, divisor, 3'b000};
  assign w_shift = {w[REM_W-3:0], 2'b00};     // 4w, top bits wrap away

  srt4_qds u_qds (
    .rem_est (w[REM_W-2 -: 7]),
    .div_est (divisor[MANT_W-2 -: 3]),
    .digit   (digit)
  );

  // magnitude of the digit picks the divisor multiple
  always_comb begin
    case (digit[1:0])
      2'b10:   qd = d2;
      2'b01,
      2'b11:   qd = d1;
      default: qd = '0;
    endcase
    w_next = digit[2] ? w_shift + qd : w_shift - qd;
  end

  // on-the-fly conversion
  assign digit_m1 = digit - 3'sd1;
  assign q_src    = digit[2] ? qm_acc : q_acc;
  assign qm_src   = (digit > 3'sd0) ? q_acc : qm_acc;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      running <= 1'b0;
      cnt     <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        running <= 1'b1;
        cnt     <= '0;
      end else if (running) begin
        cnt <= cnt + 1'b1;
        if (cnt == CNT_W'(ITER_COUNT - 1)) begin   // last step
          running <= 1'b0;
          done    <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      // x/8 against d/2, first remainder stays inside the bound
      w      <= {4'b0000, dividend};
      q_acc  <= '0;
      qm_acc <= '1;
    end else if (running) begin
      w      <= w_next;
      q_acc  <= {q_src[QUO_W-3:0], digit[1:0]};
      qm_acc <= {qm_src[QUO_W-3:0], digit_m1[1:0]};
    end
  end

  // negative remainder means Q overshot by one ulp
  assign res.quo    = w[REM_W-1] ? qm_acc : q_acc;
  assign res.sticky = |w;

endmodule

// File: rtl/fp_round_pack.sv
`timescale 1ns/1ps

module fp_round_pack (
  input  fpdiv_pkg::div_op_t  op,
  input  fpdiv_pkg::quo_raw_t raw,
  output fpdiv_pkg::fp32_u    result
);
  import fpdiv_pkg::*;

  logic                     lead;
  logic [MANT_W-1:0]        mant;
  logic                     guard, rnd, rest;
  logic                     round_up;
  logic [MANT_W:0]          mant_r;
  logic signed [EXP_DW-1:0] exp_in, exp_n, exp_r;
  logic                     ovf, unf;

  assign lead = raw.quo[QUO_W-2];   // quotient >= 1

  // a quotient below one needs a left shift by one
  assign mant  = lead ? raw.quo[QUO_W-2 -: MANT_W] : raw.quo[QUO_W-3 -: MANT_W];
  assign guard = lead ? raw.quo[2] : raw.quo[1];
  assign rnd   = lead ? raw.quo[1] : raw.quo[0];
  assign rest  = raw.sticky | (lead & raw.quo[0]);

  // nearest even
  assign round_up = guard & (rnd | rest | mant[0]);
  assign mant_r   = {1'b0, mant} + {{MANT_W{1'b0}}, round_up};

  assign exp_in = op.exp_diff;
  assign exp_n  = lead ? exp_in : exp_in - 10'sd1;
  // carry out of rounding leaves 1.000..., one more on the exponent
  assign exp_r  = exp_n + $signed({{(EXP_DW-1){1'b0}}, mant_r[MANT_W]});

  assign ovf = exp_r >= $signed({2'b00, EXP_MAX});
  assign unf = exp_r <= 0;   // flushed, no subnormal results

  always_comb begin
    result.f.sign = op.sign;
    if (ovf) begin
      result.f.exp  = EXP_MAX;
      result.f.frac = '0;
    end else if (unf) begin
      result.f.exp  = '0;
      result.f.frac = '0;
    end else begin
      result.f.exp  = exp_r[EXP_W-1:0];
      result.f.frac = mant_r[FRAC_W-1:0];   // all zero on carry-out too
    end
    if (op.special)
      result.raw = op.special_word;
  end

endmodule

// File: rtl/fpdiv_top.sv
`timescale 1ns/1ps

module fpdiv_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  output logic             in_ready,
  input  fpdiv_pkg::fp32_u in_a,
  input  fpdiv_pkg::fp32_u in_b,
  output logic             out_valid,
  input  logic             out_ready,
  output fpdiv_pkg::fp32_u out_q
);
  import fpdiv_pkg::*;

  div_op_t  op_next;
  div_op_t  op_r;      // operands of the division in flight
  quo_raw_t raw;
  fp32_u    result;
  logic     busy;
  logic     start;
  logic     done;
  logic     in_fire;

  // one division at a time, nothing accepted while a result waits
  assign in_ready = !busy && !out_valid;
  assign in_fire  = in_valid && in_ready;

  fp_unpack u_unpack (
    .a  (in_a),
    .b  (in_b),
    .op (op_next)
  );

  srt4_iter u_iter (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .dividend (op_r.mant_a),
    .divisor  (op_r.mant_b),
    .done     (done),
    .res      (raw)
  );

  fp_round_pack u_round (
    .op     (op_r),
    .raw    (raw),
    .result (result)
  );

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      busy      <= 1'b0;
      start     <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      start <= in_fire;   // core kicks off the cycle after acceptance
      if (in_fire)
        busy <= 1'b1;
      else if (done)
        busy <= 1'b0;
      if (done)
        out_valid <= 1'b1;
      else if (out_ready)
        out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire)
      op_r <= op_next;
    if (done)
      out_q <= result;   // held until the consumer takes it
  end

endmodule

// File: tb/fpdiv_assert.sv
`timescale 1ns/1ps

module fpdiv_assert (
  input logic             clk,
  input logic             rst,
  input logic             in_valid,
  input logic             in_ready,
  input logic             out_valid,
  input logic             out_ready,
  input fpdiv_pkg::fp32_u out_q
);

  // no new operands while a result is waiting
  assert property (@(posedge clk) disable iff (!rst)
    out_valid && !out_ready |=> !in_ready)
    else $error("in_ready high while a result is waiting");

  // input side reopens right after the result is taken
  assert property (@(posedge clk) disable iff (!rst)
    out_valid && out_ready |=> in_ready)
    else $error("in_ready did not return after the output transfer");

  // back-pressure freezes the output
  assert property (@(posedge clk) disable iff (!rst)
    out_valid && !out_ready |=> out_valid && $stable(out_q))
    else $error("output changed while stalled");

  // set on the 16th edge and sampled high at the 17th
  assert property (@(posedge clk) disable iff (!rst)
    in_valid && in_ready |-> ##17 $rose(out_valid))
    else $error("out_valid did not rise 16 cycles after the input transfer");

endmodule

// File: tb/fpdiv_tb.sv
`timescale 1ns/1ps

module fpdiv_tb;
  import fpdiv_pkg::*;

  localparam int TIMEOUT = 100;   // cycles allowed for any one wait
  localparam int LATENCY = 16;    // input transfer edge to out_valid

  logic  clk;
  logic  rst;
  logic  in_valid;
  logic  in_ready;
  fp32_u in_a;
  fp32_u in_b;
  logic  out_valid;
  logic  out_ready;
  fp32_u out_q;

  int errors;
  int tests;
  int passed;
  bit timed_out;

  fpdiv_top UUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_a      (in_a),
    .in_b      (in_b),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_q     (out_q)
  );

  bind fpdiv_top fpdiv_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_q     (out_q)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // one division from operand transfer to result acceptance
  task automatic run_division(input logic [31:0] a, input logic [31:0] b,
                              input logic [31:0] expect_q, input int stall);
    int    wait_cnt;
    int    lat;
    bit    ok;
    fp32_u held;
    ok = 1'b1;
    tests++;
    @(negedge clk);
    in_a.raw  = a;
    in_b.raw  = b;
    in_valid  = 1'b1;
    out_ready = (stall == 0);
    wait_cnt  = 0;
    while (!in_ready && wait_cnt < TIMEOUT) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (!in_ready) begin
      $display("test %0d: in_ready never came up, operands not accepted", tests);
      timed_out = 1'b1;
      errors++;
      return;
    end
    @(negedge clk);   // transfer edge just passed
    in_valid = 1'b0;
    lat      = 0;
    while (!out_valid && lat < TIMEOUT) begin
      @(negedge clk);
      lat++;
    end
    if (!out_valid) begin
      $display("test %0d: no result came out for %h / %h", tests, a, b);
      timed_out = 1'b1;
      errors++;
      return;
    end
    if (lat != LATENCY) begin
      $display("MISMATCH at %0t: latency %0d cycles, expected %0d", $time, lat, LATENCY);
      ok = 1'b0;
    end
    if (out_q.raw !== expect_q) begin
      $display("MISMATCH at %0t: %h / %h gave %h, expected %h",
               $time, a, b, out_q.raw, expect_q);
      ok = 1'b0;
    end
    held = out_q;
    for (int i = 0; i < stall; i++) begin
      @(negedge clk);
      if (!out_valid || out_q.raw !== held.raw) begin
        $display("MISMATCH at %0t: result %h not held under back-pressure", $time, held.raw);
        ok = 1'b0;
      end
      if (in_ready) begin
        $display("MISMATCH at %0t: in_ready high while a result waits", $time);
        ok = 1'b0;
      end
    end
    out_ready = 1'b1;
    @(negedge clk);
    out_ready = 1'b0;
    if (out_valid) begin
      $display("MISMATCH at %0t: out_valid still high after acceptance", $time);
      ok = 1'b0;
    end
    if (ok) begin
      passed++;
      $display("test %0d ok: %h / %h = %h, stall %0d", tests, a, b, expect_q, stall);
    end else begin
      errors++;
      $display("test %0d failed: %h / %h", tests, a, b);
    end
  endtask

  initial begin
    int          fd;
    int          rc;
    string       line;
    logic [31:0] a_word;
    logic [31:0] b_word;
    logic [31:0] q_word;
    int          stall;
    errors    = 0;
    tests     = 0;
    passed    = 0;
    timed_out = 1'b0;
    rst       = 1'b0;
    in_valid  = 1'b0;
    in_a.raw  = '0;
    in_b.raw  = '0;
    out_ready = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    fd = $fopen("tb/fpdiv_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the test vector file tb/fpdiv_tests.txt");
      errors++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = "";
        rc   = $fgets(line, fd);
        // comment and blank lines do not parse as four fields
        if (rc > 0 && $sscanf(line, "%h %h %h %d", a_word, b_word, q_word, stall) == 4)
          run_division(a_word, b_word, q_word, stall);
      end
      $fclose(fd);
      if (tests == 0) begin
        $display("no test vectors were read from the file");
        errors++;
      end
    end
    $display("tests run %0d, passed %0d, failed %0d", tests, passed, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// File: tb/fpdiv_tests.txt
# dividend divisor expected_quotient (binary32 hex) stall_cycles (decimal)
# stall_cycles is how long out_ready stays low once the result is valid
40c00000 40400000 40000000 0
3f800000 40800000 3e800000 2
c1100000 40400000 c0400000 0
3f800000 3f800000 3f800000 0
3f800000 40400000 3eaaaaab 0
40000000 40400000 3f2aaaab 3
41200000 40e00000 3fb6db6e 0
3f800000 40a00000 3e4ccccd 0
3f800000 41200000 3dcccccd 1
40000000 40a00000 3ecccccd 0
40400000 40a00000 3f19999a 0
40800000 40a00000 3f4ccccd 5
3f800000 40e00000 3e124925 0
40000000 40e00000 3e924925 0
40400000 40e00000 3edb6db7 0
3f800000 41100000 3de38e39 0
3f800000 41300000 3dba2e8c 4
40a00000 40400000 3fd55555 0
40800000 40400000 3faaaaab 0
40e00000 40400000 40155555 0
42c80000 40400000 42055555 0
41200000 40400000 40555555 7
3f800000 c0400000 beaaaaab 0
3fc00000 3fa00000 3f99999a 0
40400000 41200000 3e99999a 0
7fc00001 3f800000 7fc00000 0
3f800000 7f800001 7fc00000 0
7f800000 ff800000 7fc00000 0
00000000 80000000 7fc00000 0
3f800000 80000000 ff800000 0
80000000 40400000 80000000 2
3f800000 ff800000 80000000 0
7f800000 c0000000 ff800000 0
7f000000 3e800000 7f800000 0
ff000000 3e800000 ff800000 3
00800000 7f000000 00000000 0
00400000 3e800000 01000000 0
0d800000 00000200 53800000 0
00600000 00200000 40400000 0

// File: tb.f
rtl/fpdiv_pkg.sv
rtl/fp_unpack.sv
rtl/srt4_qds.sv
rtl/srt4_iter.sv
rtl/fp_round_pack.sv
rtl/fpdiv_top.sv
tb/fpdiv_assert.sv
tb/fpdiv_tb.sv

// File: Makefile
TOP = fpdiv_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tb.f $(wildcard rtl/*.sv tb/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Done: errors found" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir $(LOG)
